// ==== hdl/id_pkg.sv ====
package id_pkg;

    ////////////////////////////////////////////////////////////
    // widths and fixed registers
    ////////////////////////////////////////////////////////////

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // jal writes its return address here
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    ////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////

    // major opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // special function code, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // rt field under regimm
    typedef enum logic [4:0] {
        RI_BLTZ = 5'b00000,
        RI_BGEZ = 5'b00001
    } regimm_e;

    ////////////////////////////////////////////////////////////
    // decoded controls
    ////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_OR    = 8'b00100101,
        ALU_AND   = 8'b00100100,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLL   = 8'b01111100,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_J     = 8'b01001111,
        ALU_JAL   = 8'b01010000,
        ALU_JR    = 8'b00001000,
        ALU_BEQ   = 8'b01010001,
        ALU_BNE   = 8'b01010010,
        ALU_BGTZ  = 8'b01010100,
        ALU_BLEZ  = 8'b01010011,
        ALU_BGEZ  = 8'b01000001,
        ALU_BLTZ  = 8'b01000000
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110
    } alusel_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_J    = 4'd1,
        BR_JAL  = 4'd2,
        BR_JR   = 4'd3,
        BR_BEQ  = 4'd4,
        BR_BNE  = 4'd5,
        BR_BGTZ = 4'd6,
        BR_BLEZ = 4'd7,
        BR_BGEZ = 4'd8,
        BR_BLTZ = 4'd9
    } br_kind_e;

endpackage

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import id_pkg::*; (
    input  logic [WORD_W-1:0]     inst_i,

    output aluop_e                aluop_o,
    output alusel_e               alusel_o,
    output logic                  en_read1_o,
    output logic                  en_read2_o,
    output logic [REG_ADDR_W-1:0] read_addr1_o,
    output logic [REG_ADDR_W-1:0] read_addr2_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output logic [WORD_W-1:0]     imm_o,
    output br_kind_e              br_kind_o
);

    opcode_e               op;
    funct_e                fn;
    regimm_e               ri;
    logic [4:0]            shamt;
    logic [15:0]           imm16;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;

    assign op    = opcode_e'(inst_i[31:26]);
    assign fn    = funct_e'(inst_i[5:0]);
    assign ri    = regimm_e'(inst_i[20:16]);
    assign shamt = inst_i[10:6];
    assign imm16 = inst_i[15:0];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];

    // register ports always address rs and rt
    assign read_addr1_o = rs;
    assign read_addr2_o = rt;

    always_comb begin
        // anything not matched below stays a nop
        aluop_o    = ALU_NOP;
        alusel_o   = SEL_NOP;
        en_read1_o = 1'b0;
        en_read2_o = 1'b0;
        wd_o       = rd;
        wreg_o     = 1'b0;
        imm_o      = '0;
        br_kind_o  = BR_NONE;

        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = SEL_LOGIC;
                    FN_SLL, FN_SRL, FN_SRA,
                    FN_SLLV, FN_SRLV, FN_SRAV: alusel_o = SEL_SHIFT;
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_SLT, FN_SLTU: alusel_o = SEL_ARITH;
                    FN_JR: alusel_o = SEL_JUMP_BRANCH;
                    default: alusel_o = SEL_NOP;
                endcase

                case (fn)
                    FN_AND:  aluop_o = ALU_AND;
                    FN_OR:   aluop_o = ALU_OR;
                    FN_XOR:  aluop_o = ALU_XOR;
                    FN_NOR:  aluop_o = ALU_NOR;
                    FN_SLL, FN_SLLV: aluop_o = ALU_SLL;
                    FN_SRL, FN_SRLV: aluop_o = ALU_SRL;
                    FN_SRA, FN_SRAV: aluop_o = ALU_SRA;
                    FN_ADD:  aluop_o = ALU_ADD;
                    FN_ADDU: aluop_o = ALU_ADDU;
                    FN_SUB:  aluop_o = ALU_SUB;
                    FN_SUBU: aluop_o = ALU_SUBU;
                    FN_SLT:  aluop_o = ALU_SLT;
                    FN_SLTU: aluop_o = ALU_SLTU;
                    FN_JR:   aluop_o = ALU_JR;
                    default: aluop_o = ALU_NOP;
                endcase

                case (fn)
                    // shift amount stands in for operand 1
                    FN_SLL, FN_SRL, FN_SRA: begin
                        en_read2_o = 1'b1;
                        wreg_o     = 1'b1;
                        imm_o      = {{(WORD_W-5){1'b0}}, shamt};
                    end
                    FN_JR: begin
                        en_read1_o = 1'b1;
                        br_kind_o  = BR_JR;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: begin
                        en_read1_o = 1'b1;
                        en_read2_o = 1'b1;
                        wreg_o     = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            ////////////////////////////////////////////////////////////
            // immediate alu ops, result goes to rt
            ////////////////////////////////////////////////////////////

            OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                en_read1_o = 1'b1;
                wreg_o     = 1'b1;
                wd_o       = rt;
                case (op)
                    OP_ORI:   aluop_o = ALU_OR;
                    OP_ANDI:  aluop_o = ALU_AND;
                    OP_XORI:  aluop_o = ALU_XOR;
                    OP_LUI:   aluop_o = ALU_OR;
                    OP_ADDI:  aluop_o = ALU_ADDI;
                    OP_ADDIU: aluop_o = ALU_ADDIU;
                    OP_SLTI:  aluop_o = ALU_SLT;
                    default:  aluop_o = ALU_SLTU;
                endcase
                if (op == OP_ORI || op == OP_ANDI || op == OP_XORI) begin
                    alusel_o = SEL_LOGIC;
                    imm_o    = {16'h0, imm16};
                end else if (op == OP_LUI) begin
                    alusel_o = SEL_LOGIC;
                    imm_o    = {imm16, 16'h0};
                end else begin
                    alusel_o = SEL_ARITH;
                    imm_o    = {{16{imm16[15]}}, imm16};
                end
            end

            ////////////////////////////////////////////////////////////
            // jumps and branches
            ////////////////////////////////////////////////////////////

            OP_J: begin
                aluop_o   = ALU_J;
                alusel_o  = SEL_JUMP_BRANCH;
                br_kind_o = BR_J;
            end
            OP_JAL: begin
                aluop_o   = ALU_JAL;
                alusel_o  = SEL_JUMP_BRANCH;
                br_kind_o = BR_JAL;
                wreg_o    = 1'b1;
                wd_o      = LINK_REG;
            end
            OP_BEQ, OP_BNE: begin
                aluop_o    = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                br_kind_o  = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
                alusel_o   = SEL_JUMP_BRANCH;
                en_read1_o = 1'b1;
                en_read2_o = 1'b1;
            end
            OP_BGTZ, OP_BLEZ: begin
                aluop_o    = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
                br_kind_o  = (op == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
                alusel_o   = SEL_JUMP_BRANCH;
                en_read1_o = 1'b1;
            end
            OP_REGIMM: begin
                if (ri == RI_BGEZ || ri == RI_BLTZ) begin
                    aluop_o    = (ri == RI_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
                    br_kind_o  = (ri == RI_BGEZ) ? BR_BGEZ : BR_BLTZ;
                    alusel_o   = SEL_JUMP_BRANCH;
                    en_read1_o = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hdl/operand_mux.sv ====
`timescale 1ns/100ps

module operand_mux import id_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                  en_read_i,
    input  logic [REG_ADDR_W-1:0] read_addr_i,
    input  logic [DATA_W-1:0]     reg_data_i,
    input  logic [DATA_W-1:0]     imm_i,

    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [DATA_W-1:0]     ex_wdata_i,

    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [DATA_W-1:0]     mem_wdata_i,

    output logic [DATA_W-1:0]     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == read_addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == read_addr_i);

    // ex is younger than mem, so it wins
    always_comb begin
        if (!en_read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit import id_pkg::*; (
    input  br_kind_e          br_kind_i,
    input  logic [WORD_W-1:0] reg1_i,
    input  logic [WORD_W-1:0] reg2_i,
    input  logic [WORD_W-1:0] pc_i,
    input  logic [WORD_W-1:0] inst_i,

    output logic              branch_flag_o,
    output logic [WORD_W-1:0] branch_target_addr_o,
    output logic              next_inst_delayslot_o,
    output logic [WORD_W-1:0] link_addr_o
);

    logic [WORD_W-1:0] pc4;
    logic [WORD_W-1:0] pc8;
    logic [WORD_W-1:0] jump_target;
    logic [WORD_W-1:0] rel_target;
    logic              reg1_neg;
    logic              reg1_zero;
    logic              taken;

    assign pc4 = pc_i + 32'd4;
    assign pc8 = pc_i + 32'd8;

    // region jump keeps the top nibble of the delay slot pc
    assign jump_target = {pc4[31:28], inst_i[25:0], 2'b00};
    assign rel_target  = pc4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    assign reg1_neg  = reg1_i[WORD_W-1];
    assign reg1_zero = (reg1_i == '0);

    always_comb begin
        case (br_kind_i)
            BR_J, BR_JAL, BR_JR: taken = 1'b1;
            BR_BEQ:  taken = (reg1_i == reg2_i);
            BR_BNE:  taken = (reg1_i != reg2_i);
            BR_BGTZ: taken = !reg1_neg && !reg1_zero;
            BR_BLEZ: taken = reg1_neg || reg1_zero;
            BR_BGEZ: taken = !reg1_neg;
            BR_BLTZ: taken = reg1_neg;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_flag_o         = taken;
        next_inst_delayslot_o = taken;
        branch_target_addr_o  = '0;
        if (taken) begin
            case (br_kind_i)
                BR_J, BR_JAL: branch_target_addr_o = jump_target;
                BR_JR:        branch_target_addr_o = reg1_i;
                default:      branch_target_addr_o = rel_target;
            endcase
        end
    end

    // return address skips the delay slot
    assign link_addr_o = (br_kind_i == BR_JAL) ? pc8 : '0;

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/100ps

module id_stage import id_pkg::*; #(
    parameter int DATA_W = WORD_W
) (
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic [WORD_W-1:0]     pc_i,
    input  logic [WORD_W-1:0]     inst_i,
    input  logic                  is_in_delayslot_i,

    input  logic [DATA_W-1:0]     reg_data1_i,
    input  logic [DATA_W-1:0]     reg_data2_i,
    output logic                  en_reg_read1_o,
    output logic                  en_reg_read2_o,
    output logic [REG_ADDR_W-1:0] reg_addr1_o,
    output logic [REG_ADDR_W-1:0] reg_addr2_o,

    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [DATA_W-1:0]     ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [DATA_W-1:0]     mem_wdata_i,

    output logic                  branch_flag_o,
    output logic [WORD_W-1:0]     branch_target_addr_o,
    output logic                  next_inst_delayslot_o,

    output aluop_e                aluop_o,
    output alusel_e               alusel_o,
    output logic [DATA_W-1:0]     reg1_o,
    output logic [DATA_W-1:0]     reg2_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output logic [WORD_W-1:0]     link_addr_o,
    output logic                  is_in_delayslot_o
);

    aluop_e                aluop;
    alusel_e               alusel;
    br_kind_e              br_kind;
    logic                  en_read1;
    logic                  en_read2;
    logic [REG_ADDR_W-1:0] read_addr1;
    logic [REG_ADDR_W-1:0] read_addr2;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic [WORD_W-1:0]     imm;
    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;
    logic                  branch_flag;
    logic [WORD_W-1:0]     branch_target;
    logic                  next_delayslot;
    logic [WORD_W-1:0]     link_addr;

    inst_decoder u_decoder (
        .inst_i       (inst_i),
        .aluop_o      (aluop),
        .alusel_o     (alusel),
        .en_read1_o   (en_read1),
        .en_read2_o   (en_read2),
        .read_addr1_o (read_addr1),
        .read_addr2_o (read_addr2),
        .wd_o         (wd),
        .wreg_o       (wreg),
        .imm_o        (imm),
        .br_kind_o    (br_kind)
    );

    operand_mux #(.DATA_W(DATA_W)) u_mux1 (
        .en_read_i   (en_read1),
        .read_addr_i (read_addr1),
        .reg_data_i  (reg_data1_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    operand_mux #(.DATA_W(DATA_W)) u_mux2 (
        .en_read_i   (en_read2),
        .read_addr_i (read_addr2),
        .reg_data_i  (reg_data2_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    branch_unit u_branch (
        .br_kind_i             (br_kind),
        .reg1_i                (reg1),
        .reg2_i                (reg2),
        .pc_i                  (pc_i),
        .inst_i                (inst_i),
        .branch_flag_o         (branch_flag),
        .branch_target_addr_o  (branch_target),
        .next_inst_delayslot_o (next_delayslot),
        .link_addr_o           (link_addr)
    );

    ////////////////////////////////////////////////////////////
    // same-cycle outputs, held inactive in reset
    ////////////////////////////////////////////////////////////

    assign en_reg_read1_o        = en_read1 & ~rst_i;
    assign en_reg_read2_o        = en_read2 & ~rst_i;
    assign reg_addr1_o           = rst_i ? '0 : read_addr1;
    assign reg_addr2_o           = rst_i ? '0 : read_addr2;
    assign branch_flag_o         = branch_flag & ~rst_i;
    assign branch_target_addr_o  = rst_i ? '0 : branch_target;
    assign next_inst_delayslot_o = next_delayslot & ~rst_i;

    ////////////////////////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            aluop_o           <= ALU_NOP;
            alusel_o          <= SEL_NOP;
            reg1_o            <= '0;
            reg2_o            <= '0;
            wd_o              <= '0;
            wreg_o            <= 1'b0;
            link_addr_o       <= '0;
            is_in_delayslot_o <= 1'b0;
        end else begin
            aluop_o           <= aluop;
            alusel_o          <= alusel;
            reg1_o            <= reg1;
            reg2_o            <= reg2;
            wd_o              <= wd;
            wreg_o            <= wreg;
            link_addr_o       <= link_addr;
            is_in_delayslot_o <= is_in_delayslot_i;
        end
    end

endmodule

// ==== tests/id_stage_assertions.sv ====
`timescale 1ns/100ps

module id_stage_assertions import id_pkg::*; (
    input logic              clk,
    input logic              rst_i,
    input logic [WORD_W-1:0] inst_i,
    input logic              wreg_o,
    input logic              branch_flag_o,
    input logic              next_inst_delayslot_o,
    input logic [WORD_W-1:0] branch_target_addr_o
);

    // a reset edge leaves the id/ex register without a write
    a_wreg_after_reset: assert property (@(posedge clk) rst_i |=> !wreg_o)
        else $error("wreg_o high in the cycle after reset");

    a_flag_is_delayslot: assert property (
        @(posedge clk) branch_flag_o == next_inst_delayslot_o)
        else $error("branch_flag_o and next_inst_delayslot_o differ");

    // jr is the only special-opcode branch and may target any address
    a_target_aligned: assert property (
        @(posedge clk) (branch_flag_o && inst_i[31:26] != OP_SPECIAL)
            |-> branch_target_addr_o[1:0] == 2'b00)
        else $error("taken branch target not word aligned");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk                   (clk),
    .rst_i                 (rst_i),
    .inst_i                (inst_i),
    .wreg_o                (wreg_o),
    .branch_flag_o         (branch_flag_o),
    .next_inst_delayslot_o (next_inst_delayslot_o),
    .branch_target_addr_o  (branch_target_addr_o)
);

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/100ps

module id_stage_tb import id_pkg::*; ();

    localparam int N_CYCLES = 3000;

    typedef struct {
        aluop_e      aluop;
        alusel_e     alusel;
        logic        en1;
        logic        en2;
        logic [4:0]  addr1;
        logic [4:0]  addr2;
        logic [4:0]  wd;
        logic        wreg;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic [31:0] link;
        logic        flag;
        logic [31:0] target;
        logic        dslot;
    } exp_t;

    logic        clk;
    logic        rst_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic        is_in_delayslot_i;
    logic [31:0] reg_data1_i;
    logic [31:0] reg_data2_i;
    logic        en_reg_read1_o;
    logic        en_reg_read2_o;
    logic [4:0]  reg_addr1_o;
    logic [4:0]  reg_addr2_o;
    logic        ex_wreg_i;
    logic [4:0]  ex_wd_i;
    logic [31:0] ex_wdata_i;
    logic        mem_wreg_i;
    logic [4:0]  mem_wd_i;
    logic [31:0] mem_wdata_i;
    logic        branch_flag_o;
    logic [31:0] branch_target_addr_o;
    logic        next_inst_delayslot_o;
    aluop_e      aluop_o;
    alusel_e     alusel_o;
    logic [31:0] reg1_o;
    logic [31:0] reg2_o;
    logic [4:0]  wd_o;
    logic        wreg_o;
    logic [31:0] link_addr_o;
    logic        is_in_delayslot_o;

    logic [31:0] rf [32];
    logic [31:0] seed;
    exp_t        cur_exp;
    int          checked;

    id_stage #(.DATA_W(WORD_W)) UUT (.*);

    // register file answers combinationally
    assign reg_data1_i = rf[reg_addr1_o];
    assign reg_data2_i = rf[reg_addr2_o];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // small pool so zero, negative and equal operands come up often
    function automatic logic [31:0] pick_value();
        logic [31:0] r;
        r = xorshift();
        case (r[2:0])
            3'd0: return 32'h0;
            3'd1: return 32'h1;
            3'd2: return 32'h8000_0000;
            3'd3: return 32'hffff_ffff;
            default: return xorshift();
        endcase
    endfunction

    function automatic logic [31:0] forward(logic en, logic [4:0] addr, logic [31:0] imm);
        if (!en) return imm;
        if (ex_wreg_i && ex_wd_i == addr) return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == addr) return mem_wdata_i;
        return rf[addr];
    endfunction

    function automatic exp_t reset_exp();
        exp_t e;
        e = '{ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        return e;
    endfunction

    function automatic exp_t decode_ref(logic [31:0] inst, logic [31:0] pc, logic ds);
        exp_t        e;
        logic [31:0] imm;
        logic [31:0] pc4;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic        is_j;
        logic        cond;
        e = reset_exp();
        op = inst[31:26];
        fn = inst[5:0];
        pc4 = pc + 32'd4;
        imm = 32'h0;
        is_j = 1'b0;
        cond = 1'b0;
        e.addr1 = inst[25:21];
        e.addr2 = inst[20:16];
        e.wd = inst[15:11];
        e.dslot = ds;
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_AND:  e.aluop = ALU_AND;
                FN_OR:   e.aluop = ALU_OR;
                FN_XOR:  e.aluop = ALU_XOR;
                FN_NOR:  e.aluop = ALU_NOR;
                FN_SLL, FN_SLLV: e.aluop = ALU_SLL;
                FN_SRL, FN_SRLV: e.aluop = ALU_SRL;
                FN_SRA, FN_SRAV: e.aluop = ALU_SRA;
                FN_ADD:  e.aluop = ALU_ADD;
                FN_ADDU: e.aluop = ALU_ADDU;
                FN_SUB:  e.aluop = ALU_SUB;
                FN_SUBU: e.aluop = ALU_SUBU;
                FN_SLT:  e.aluop = ALU_SLT;
                FN_SLTU: e.aluop = ALU_SLTU;
                FN_JR:   e.aluop = ALU_JR;
                default: e.aluop = ALU_NOP;
            endcase
            if (fn inside {FN_AND, FN_OR, FN_XOR, FN_NOR}) e.alusel = SEL_LOGIC;
            else if (fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV})
                e.alusel = SEL_SHIFT;
            else if (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU})
                e.alusel = SEL_ARITH;
            else if (fn == FN_JR) e.alusel = SEL_JUMP_BRANCH;
            if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                e.en2 = 1'b1;
                e.wreg = 1'b1;
                imm = {27'h0, inst[10:6]};
            end else if (fn == FN_JR) begin
                e.en1 = 1'b1;
                e.flag = 1'b1;
                is_j = 1'b1;
            end else if (e.alusel != SEL_NOP) begin
                e.en1 = 1'b1;
                e.en2 = 1'b1;
                e.wreg = 1'b1;
            end
        end else if (op inside {OP_ORI, OP_ANDI, OP_XORI}) begin
            e.aluop = (op == OP_ORI) ? ALU_OR : (op == OP_ANDI) ? ALU_AND : ALU_XOR;
            e.alusel = SEL_LOGIC;
            imm = {16'h0, inst[15:0]};
        end else if (op == OP_LUI) begin
            e.aluop = ALU_OR;
            e.alusel = SEL_LOGIC;
            imm = {inst[15:0], 16'h0};
        end else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
            e.aluop = (op == OP_ADDI) ? ALU_ADDI : (op == OP_ADDIU) ? ALU_ADDIU :
                      (op == OP_SLTI) ? ALU_SLT : ALU_SLTU;
            e.alusel = SEL_ARITH;
            imm = {{16{inst[15]}}, inst[15:0]};
        end else if (op == OP_J || op == OP_JAL) begin
            e.aluop = (op == OP_J) ? ALU_J : ALU_JAL;
            e.alusel = SEL_JUMP_BRANCH;
            e.flag = 1'b1;
            e.target = {pc4[31:28], inst[25:0], 2'b00};
            if (op == OP_JAL) begin
                e.wreg = 1'b1;
                e.wd = LINK_REG;
                e.link = pc + 32'd8;
            end
        end else if (op inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ}) begin
            e.aluop = (op == OP_BEQ) ? ALU_BEQ : (op == OP_BNE) ? ALU_BNE :
                      (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
            e.alusel = SEL_JUMP_BRANCH;
            e.en1 = 1'b1;
            e.en2 = (op == OP_BEQ || op == OP_BNE);
            cond = 1'b1;
        end else if (op == OP_REGIMM && inst[20:17] == 4'h0) begin
            e.aluop = inst[16] ? ALU_BGEZ : ALU_BLTZ;
            e.alusel = SEL_JUMP_BRANCH;
            e.en1 = 1'b1;
            cond = 1'b1;
        end
        if (op inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
                       OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
            e.en1 = 1'b1;
            e.wreg = 1'b1;
            e.wd = inst[20:16];
        end
        e.reg1 = forward(e.en1, e.addr1, imm);
        e.reg2 = forward(e.en2, e.addr2, imm);
        if (is_j) e.target = e.reg1;
        if (cond) begin
            case (e.aluop)
                ALU_BEQ:  e.flag = (e.reg1 == e.reg2);
                ALU_BNE:  e.flag = (e.reg1 != e.reg2);
                ALU_BGTZ: e.flag = ($signed(e.reg1) > 0);
                ALU_BLEZ: e.flag = ($signed(e.reg1) <= 0);
                ALU_BGEZ: e.flag = ($signed(e.reg1) >= 0);
                default:  e.flag = ($signed(e.reg1) < 0);
            endcase
            if (e.flag) e.target = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_failure(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_aluop(string name, aluop_e got, aluop_e exp);
        if (got !== exp)
            stop_on_failure($sformatf("Error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_alusel(string name, alusel_e got, alusel_e exp);
        if (got !== exp)
            stop_on_failure($sformatf("Error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            stop_on_failure($sformatf("Error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            stop_on_failure($sformatf("Error %s got %h expected %h", name, got, exp));
    endtask

    // same-cycle outputs just before the edge, registered ones just after
    initial begin : compare
        exp_t pend;
        @(posedge clk);
        forever begin
            @(negedge clk);
            #4;
            check_bit("en_reg_read1_o", en_reg_read1_o, cur_exp.en1);
            check_bit("en_reg_read2_o", en_reg_read2_o, cur_exp.en2);
            check_word("reg_addr1_o", {27'h0, reg_addr1_o}, {27'h0, cur_exp.addr1});
            check_word("reg_addr2_o", {27'h0, reg_addr2_o}, {27'h0, cur_exp.addr2});
            check_bit("branch_flag_o", branch_flag_o, cur_exp.flag);
            check_word("branch_target_addr_o", branch_target_addr_o, cur_exp.target);
            check_bit("next_inst_delayslot_o", next_inst_delayslot_o, cur_exp.flag);
            pend = cur_exp;
            @(posedge clk);
            #1;
            check_aluop("aluop_o", aluop_o, pend.aluop);
            check_alusel("alusel_o", alusel_o, pend.alusel);
            check_word("reg1_o", reg1_o, pend.reg1);
            check_word("reg2_o", reg2_o, pend.reg2);
            check_word("wd_o", {27'h0, wd_o}, {27'h0, pend.wd});
            check_bit("wreg_o", wreg_o, pend.wreg);
            check_word("link_addr_o", link_addr_o, pend.link);
            check_bit("is_in_delayslot_o", is_in_delayslot_o, pend.dslot);
            checked++;
        end
    end

    task automatic make_inst();
        logic [31:0] r;
        logic [5:0]  op;
        funct_e      fns [17];
        opcode_e     ops [8];
        fns = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_ADD, FN_ADDU,
                FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
        ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        r = xorshift();
        inst_i = xorshift();
        case (r[2:0])
            3'd0, 3'd1, 3'd2: inst_i = {6'h0, inst_i[25:6], fns[r[31:8] % 17]};
            3'd3: inst_i[31:26] = ops[r[5:3]];
            3'd4: inst_i[31:26] = r[3] ? OP_JAL : OP_J;
            3'd5: begin
                op = OP_BEQ + r[4:3];
                inst_i[31:26] = op;
            end
            3'd6: inst_i = {OP_REGIMM, inst_i[25:21], 4'h0, r[3], inst_i[15:0]};
            default: begin
            end
        endcase
    endtask

    initial begin : drive
        logic [31:0] r;
        seed = 32'd21256;
        checked = 0;
        rst_i = 1'b1;
        pc_i = '0;
        inst_i = '0;
        is_in_delayslot_i = 1'b0;
        ex_wreg_i = 1'b0;
        ex_wd_i = '0;
        ex_wdata_i = '0;
        mem_wreg_i = 1'b0;
        mem_wd_i = '0;
        mem_wdata_i = '0;
        for (int i = 0; i < 32; i++) rf[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'h3c};
        cur_exp = reset_exp();
        for (int i = 0; i < N_CYCLES; i++) begin
            @(negedge clk);
            if (i == 3) rst_i = 1'b0;
            make_inst();
            r = xorshift();
            // instruction addresses are word aligned
            pc_i = xorshift() & 32'hffff_fffc;
            is_in_delayslot_i = r[0];
            rf[inst_i[25:21]] = pick_value();
            rf[inst_i[20:16]] = pick_value();
            ex_wreg_i = r[1];
            ex_wd_i = r[2] ? inst_i[25:21] : r[12:8];
            ex_wdata_i = pick_value();
            mem_wreg_i = r[3];
            // equal destinations show that ex wins over mem
            mem_wd_i = (r[5:4] == 2'b00) ? ex_wd_i : (r[6] ? inst_i[20:16] : r[20:16]);
            mem_wdata_i = pick_value();
            cur_exp = rst_i ? reset_exp() : decode_ref(inst_i, pc_i, is_in_delayslot_i);
        end
        for (int t = 0; t < 20 && checked < N_CYCLES; t++) @(posedge clk);
        #2;
        if (checked < N_CYCLES) begin
            stop_on_failure("timeout waiting for the last compare");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_unit.sv
hdl/id_stage.sv
tests/id_stage_assertions.sv
tests/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module id_stage_tb
out=$(./obj_dir/Vid_stage_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -q "all tests passed"; then
    exit 0
else
    exit 1
fi
